// File: run_sim.sh
#!/bin/bash
# build and run the scalefactor parser testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module sf_parser_tb \
  -o sf_parser_sim \
  && ./obj_dir/sf_parser_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null \
  && { echo "RESULT: PASS"; exit 0; } \
  || { echo "RESULT: FAIL"; exit 1; }

// File: src/sf_field_walker.sv
`include "sf_settings.svh"

module sf_field_walker (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 si_valid,
  input  logic                 sdata,
  input  logic                 sdata_valid,
  input  sf_pkg::slen_t        slen1,
  input  sf_pkg::slen_t        slen2,
  input  logic                 short_mode,
  output logic                 frame_start,
  output logic                 field_valid,
  output sf_pkg::field_idx_t   field_idx,
  output logic [`SF_WIDTH-1:0] field_value,
  output logic                 frame_end
);

  import sf_pkg::*;

  logic                 active;
  field_idx_t           idx;
  slen_t                bit_cnt;   // bits taken in the current field
  logic [`SF_WIDTH-1:0] acc;

  field_idx_t           split;
  field_idx_t           last_idx;
  field_idx_t           eff_idx;
  slen_t                eff_w;
  logic                 take;
  logic                 field_done;
  logic                 final_field;
  logic [`SF_WIDTH-1:0] acc_next;

  assign split    = short_mode ? field_idx_t'(`SF_SHORT_SPLIT) : field_idx_t'(`SF_LONG_SPLIT);
  assign last_idx = short_mode ? field_idx_t'(`SF_FIELDS - 1)
                               : field_idx_t'(`SF_LONG_BANDS - 1);

  // an empty first region is skipped straight to the split
  always_comb begin
    if ((idx < split) && (slen1 == '0)) begin
      eff_idx = split;
      eff_w   = slen2;
    end else begin
      eff_idx = idx;
      eff_w   = (idx < split) ? slen1 : slen2;
    end
  end

  // a new strobe wins over any bit in the same cycle
  assign take     = active && sdata_valid && !si_valid;
  assign acc_next = {acc[`SF_WIDTH-2:0], sdata};  // msb first

  assign field_done = take && (eff_w != '0) && ((bit_cnt + slen_t'(1)) == eff_w);

  // last field overall, or last of region 1 when region 2 is empty
  assign final_field = (eff_idx == last_idx) ||
                       ((eff_idx == (split - field_idx_t'(1))) && (slen2 == '0));

  assign frame_start = si_valid;
  assign field_valid = field_done;
  assign field_idx   = eff_idx;
  assign field_value = acc_next;  // upper bits stay zero for narrow fields
  assign frame_end   = active && !si_valid &&
                       ((eff_w == '0) || (field_done && final_field));

  always_ff @(posedge clk) begin
    if (rst) begin
      active  <= 1'b0;
      idx     <= '0;
      bit_cnt <= '0;
      acc     <= '0;
    end else if (si_valid) begin
      active  <= 1'b1;  // also aborts a frame in flight
      idx     <= '0;
      bit_cnt <= '0;
      acc     <= '0;
    end else if (active) begin
      if (frame_end) begin
        active <= 1'b0;
      end
      if (field_done) begin
        idx     <= eff_idx + field_idx_t'(1);
        bit_cnt <= '0;
        acc     <= '0;
      end else begin
        idx <= eff_idx;
        if (take) begin
          bit_cnt <= bit_cnt + slen_t'(1);
          acc     <= acc_next;
        end
      end
    end
  end

endmodule

// File: src/sf_parser.sv
`include "sf_settings.svh"

module sf_parser (
  input  logic       clk,
  input  logic       rst,
  input  logic       si_valid,
  input  logic [3:0] scalefac_compress,
  input  logic       window_switching_flag,
  input  logic [1:0] block_type,
  input  logic       sdata,
  input  logic       sdata_valid,
  output logic [`SF_LONG_BANDS-1:0][`SF_WIDTH-1:0] scalefac_l,
  output logic [`SF_SHORT_BANDS-1:0][`SF_WINDOWS-1:0][`SF_WIDTH-1:0] scalefac_s,
  output logic       done
);

  import sf_pkg::*;

  slen_t                slen1;
  slen_t                slen2;
  logic                 short_mode;
  logic                 frame_start;
  logic                 field_valid;
  field_idx_t           field_idx;
  logic [`SF_WIDTH-1:0] field_value;
  logic                 frame_end;
  sf_bank_u             bank;

  sf_slen_decode i_sf_slen_decode (
    .clk                   (clk),
    .rst                   (rst),
    .si_valid              (si_valid),
    .scalefac_compress     (scalefac_compress),
    .window_switching_flag (window_switching_flag),
    .block_type            (block_type),
    .slen1                 (slen1),
    .slen2                 (slen2),
    .short_mode            (short_mode)
  );

  sf_field_walker i_sf_field_walker (
    .clk         (clk),
    .rst         (rst),
    .si_valid    (si_valid),
    .sdata       (sdata),
    .sdata_valid (sdata_valid),
    .slen1       (slen1),
    .slen2       (slen2),
    .short_mode  (short_mode),
    .frame_start (frame_start),
    .field_valid (field_valid),
    .field_idx   (field_idx),
    .field_value (field_value),
    .frame_end   (frame_end)
  );

  sf_store i_sf_store (
    .clk         (clk),
    .rst         (rst),
    .frame_start (frame_start),
    .field_valid (field_valid),
    .field_idx   (field_idx),
    .field_value (field_value),
    .frame_end   (frame_end),
    .bank        (bank),
    .done        (done)
  );

  // same bank, two readings
  assign scalefac_l = bank.long_view.bands;
  assign scalefac_s = bank.short_view;

endmodule

// File: src/sf_pkg.sv
`include "sf_settings.svh"

package sf_pkg;

  // width of one field, 0 to 4
  typedef logic [2:0] slen_t;

  // position of a field in the bank
  typedef logic [5:0] field_idx_t;

  // one bank word, read either as long bands or as band x window
  typedef union packed {
    logic [`SF_FIELDS-1:0][`SF_WIDTH-1:0] flat;  // write side
    logic [`SF_SHORT_BANDS-1:0][`SF_WINDOWS-1:0][`SF_WIDTH-1:0] short_view;
    struct packed {
      logic [(`SF_FIELDS-`SF_LONG_BANDS)*`SF_WIDTH-1:0] pad;  // unused in long mode
      logic [`SF_LONG_BANDS-1:0][`SF_WIDTH-1:0] bands;
    } long_view;
  } sf_bank_u;

endpackage

// File: src/sf_settings.svh
`ifndef SF_SETTINGS_SVH
`define SF_SETTINGS_SVH

`define SF_WIDTH        4   // widest scalefactor field
`define SF_LONG_BANDS   21
`define SF_SHORT_BANDS  12
`define SF_WINDOWS      3
`define SF_FIELDS       36  // bank slots, short blocks fill all of them

// first field index read with slen2
`define SF_LONG_SPLIT   11
`define SF_SHORT_SPLIT  18

`define SF_BLOCK_SHORT  2   // block_type code for short blocks

`endif

// File: src/sf_slen_decode.sv
`include "sf_settings.svh"

module sf_slen_decode (
  input  logic          clk,
  input  logic          rst,
  input  logic          si_valid,
  input  logic [3:0]    scalefac_compress,
  input  logic          window_switching_flag,
  input  logic [1:0]    block_type,
  output sf_pkg::slen_t slen1,
  output sf_pkg::slen_t slen2,
  output logic          short_mode
);

  logic [3:0] sfc_q;
  logic       wsf_q;
  logic [1:0] bt_q;

  // side info holds until the next strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      sfc_q <= '0;
      wsf_q <= 1'b0;
      bt_q  <= '0;
    end else if (si_valid) begin
      sfc_q <= scalefac_compress;
      wsf_q <= window_switching_flag;
      bt_q  <= block_type;
    end
  end

  // scalefac_compress table, slen1 / slen2
  always_comb begin
    case (sfc_q)
      4'd0:    begin slen1 = 3'd0; slen2 = 3'd0; end
      4'd1:    begin slen1 = 3'd0; slen2 = 3'd1; end
      4'd2:    begin slen1 = 3'd0; slen2 = 3'd2; end
      4'd3:    begin slen1 = 3'd0; slen2 = 3'd3; end
      4'd4:    begin slen1 = 3'd3; slen2 = 3'd0; end
      4'd5:    begin slen1 = 3'd1; slen2 = 3'd1; end
      4'd6:    begin slen1 = 3'd1; slen2 = 3'd2; end
      4'd7:    begin slen1 = 3'd1; slen2 = 3'd3; end
      4'd8:    begin slen1 = 3'd2; slen2 = 3'd1; end
      4'd9:    begin slen1 = 3'd2; slen2 = 3'd2; end
      4'd10:   begin slen1 = 3'd2; slen2 = 3'd3; end
      4'd11:   begin slen1 = 3'd3; slen2 = 3'd1; end
      4'd12:   begin slen1 = 3'd3; slen2 = 3'd2; end
      4'd13:   begin slen1 = 3'd3; slen2 = 3'd3; end
      4'd14:   begin slen1 = 3'd4; slen2 = 3'd2; end
      default: begin slen1 = 3'd4; slen2 = 3'd3; end
    endcase
  end

  assign short_mode = wsf_q && (bt_q == 2'(`SF_BLOCK_SHORT));

endmodule

// File: src/sf_store.sv
`include "sf_settings.svh"

module sf_store (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 frame_start,
  input  logic                 field_valid,
  input  sf_pkg::field_idx_t   field_idx,
  input  logic [`SF_WIDTH-1:0] field_value,
  input  logic                 frame_end,
  output sf_pkg::sf_bank_u     bank,
  output logic                 done
);

  // fields land in flat slot order, the top picks the view
  always_ff @(posedge clk) begin
    if (rst) begin
      bank <= '0;
    end else if (frame_start) begin
      bank <= '0;  // skipped regions read as zero
    end else if (field_valid) begin
      bank.flat[field_idx] <= field_value;
    end
  end

  // last field is written on the same edge, so done sees a full bank
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= frame_end;
    end
  end

endmodule

// File: verification/sf_parser_chk.sv
module sf_parser_chk (
  input logic clk,
  input logic rst,
  input logic si_valid,
  input logic done
);

  timeunit 1ns;
  timeprecision 1ps;

  // done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) done |=> !done)
    else $error("done held high for two cycles");

  // covers the reset cycles and the first cycle out of reset
  done_low_after_rst: assert property (@(posedge clk) rst |=> !done ##1 !done)
    else $error("done high during or right after reset");

  // a strobe restarts the walker, no frame can end one cycle later
  no_done_after_si: assert property (@(posedge clk) si_valid |=> !done)
    else $error("done rose in the cycle after si_valid");

endmodule

bind sf_parser sf_parser_chk i_sf_parser_chk (
  .clk      (clk),
  .rst      (rst),
  .si_valid (si_valid),
  .done     (done)
);

// File: verification/sf_parser_tb.sv
`include "sf_settings.svh"

module sf_parser_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import sf_pkg::*;

  localparam int MAX_FRAMES = 64;
  localparam int COLS       = `SF_FIELDS + 3;  // id, mode, compress, values

  logic       clk;
  logic       rst;
  logic       si_valid;
  logic [3:0] scalefac_compress;
  logic       window_switching_flag;
  logic [1:0] block_type;
  logic       sdata;
  logic       sdata_valid;
  logic [`SF_LONG_BANDS-1:0][`SF_WIDTH-1:0] scalefac_l;
  logic [`SF_SHORT_BANDS-1:0][`SF_WINDOWS-1:0][`SF_WIDTH-1:0] scalefac_s;
  logic       done;

  logic [7:0]  tdata [0:MAX_FRAMES*COLS-1];
  int          n_frames;
  int          errors;
  int          tests_ok;
  logic [31:0] lfsr_state = 32'h3a591d75;

  sf_parser i_sf_parser (
    .clk                   (clk),
    .rst                   (rst),
    .si_valid              (si_valid),
    .scalefac_compress     (scalefac_compress),
    .window_switching_flag (window_switching_flag),
    .block_type            (block_type),
    .sdata                 (sdata),
    .sdata_valid           (sdata_valid),
    .scalefac_l            (scalefac_l),
    .scalefac_s            (scalefac_s),
    .done                  (done)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // slen1 / slen2 per scalefac_compress, from the layer III table
  function automatic slen_t slen_lookup(input logic [3:0] sfc, input logic second);
    slen_t t1 [16];
    slen_t t2 [16];
    t1 = '{3'd0, 3'd0, 3'd0, 3'd0, 3'd3, 3'd1, 3'd1, 3'd1,
           3'd2, 3'd2, 3'd2, 3'd3, 3'd3, 3'd3, 3'd4, 3'd4};
    t2 = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd0, 3'd1, 3'd2, 3'd3,
           3'd1, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd2, 3'd3};
    return second ? t2[sfc] : t1[sfc];
  endfunction

  function automatic slen_t field_width(input logic [3:0] sfc, input logic short_blk,
                                        input int k);
    int split;
    split = short_blk ? `SF_SHORT_SPLIT : `SF_LONG_SPLIT;
    return slen_lookup(sfc, k >= split);
  endfunction

  // strobe side info, leaves the bus idle at the next falling edge
  task automatic start_frame(input logic [3:0] sfc, input logic [3:0] mode);
    si_valid              = 1'b1;
    sdata_valid           = 1'b0;
    scalefac_compress     = sfc;
    window_switching_flag = mode[0] | mode[3];
    block_type            = mode[0] ? 2'(`SF_BLOCK_SHORT) : (mode[3] ? 2'd1 : 2'd0);
    @(negedge clk);
    si_valid = 1'b0;
  endtask

  // one bit, sometimes after an idle cycle
  task automatic send_bit(input logic b);
    logic g1;
    logic g2;
    assert (!done) else begin
      $display("ERR %0t: done high before the frame was complete", $time);
      errors++;
    end
    g1 = lfsr_bit();
    g2 = lfsr_bit();
    if (g1 && g2) begin
      sdata_valid = 1'b0;
      sdata       = lfsr_bit();  // noise on the idle cycle
      @(negedge clk);
      assert (!done) else begin
        $display("ERR %0t: done high in an idle cycle of the frame", $time);
        errors++;
      end
    end
    sdata_valid = 1'b1;
    sdata       = b;
    @(negedge clk);
  endtask

  task automatic run_frame(input int f);
    int           base;
    int           id;
    int           nf;
    int           nbits;
    int           lat;
    int           exp_lat;
    int           err_before;
    logic [3:0]   mode;
    logic [3:0]   sfc;
    logic         short_blk;
    slen_t        w;
    logic [3:0]   exp_val [`SF_FIELDS];
    base       = f * COLS;
    id         = int'(tdata[base]);
    mode       = tdata[base+1][3:0];
    sfc        = tdata[base+2][3:0];
    short_blk  = mode[0];
    err_before = errors;
    nf         = short_blk ? `SF_FIELDS : `SF_LONG_BANDS;
    nbits      = 0;
    for (int k = 0; k < `SF_FIELDS; k++) begin
      exp_val[k] = tdata[base+3+k][3:0];
      if (k < nf) nbits += int'(field_width(sfc, short_blk, k));
    end

    if (mode[1]) begin  // half a frame of junk, then a fresh strobe
      start_frame(sfc, mode);
      for (int i = 0; i < nbits / 2; i++) send_bit(lfsr_bit());
      sdata_valid = 1'b0;
    end

    start_frame(sfc, mode);
    for (int k = 0; k < nf; k++) begin
      w = field_width(sfc, short_blk, k);
      for (int b = int'(w) - 1; b >= 0; b--) send_bit(exp_val[k][b]);
    end
    sdata_valid = 1'b0;

    exp_lat = (nbits == 0) ? 1 : 0;
    lat     = 0;
    while (!done && lat < 8) begin
      @(negedge clk);
      lat++;
    end
    assert (done) else begin
      $display("test %0d: done never arrived after the frame", id);
      errors++;
    end
    if (done) begin
      assert (lat == exp_lat) else begin
        $display("ERR %0t: test %0d done after %0d extra cycles, expected %0d",
                 $time, id, lat, exp_lat);
        errors++;
      end
    end
    @(negedge clk);
    assert (!done) else begin
      $display("ERR %0t: test %0d done longer than one cycle", $time, id);
      errors++;
    end

    if (mode[2]) begin  // stray bits must not touch the bank
      for (int i = 0; i < 5; i++) send_bit(lfsr_bit());
      sdata_valid = 1'b0;
      @(negedge clk);
      assert (!done) else begin
        $display("ERR %0t: test %0d done after stray bits", $time, id);
        errors++;
      end
    end

    for (int k = 0; k < nf; k++) begin
      if (short_blk) begin
        assert (scalefac_s[k/3][k%3] == exp_val[k]) else begin
          $display("ERR %0t: test %0d short field %0d got %h expected %h",
                   $time, id, k, scalefac_s[k/3][k%3], exp_val[k]);
          errors++;
        end
      end else begin
        assert (scalefac_l[k] == exp_val[k]) else begin
          $display("ERR %0t: test %0d long field %0d got %h expected %h",
                   $time, id, k, scalefac_l[k], exp_val[k]);
          errors++;
        end
      end
    end

    if (errors == err_before) tests_ok++;
    $display("test %0d %s sfc %0d mode %h bits %0d: %s", id,
             short_blk ? "short" : "long", sfc, mode, nbits,
             (errors == err_before) ? "ok" : "FAILED");
  endtask

  initial begin
    rst                   = 1'b1;
    si_valid              = 1'b0;
    scalefac_compress     = '0;
    window_switching_flag = 1'b0;
    block_type            = '0;
    sdata                 = 1'b0;
    sdata_valid           = 1'b0;
    errors                = 0;
    tests_ok              = 0;
    for (int i = 0; i < MAX_FRAMES * COLS; i++) tdata[i] = '0;
    $readmemh("verification/sf_parser_testdata.txt", tdata);
    n_frames = 0;
    while (n_frames < MAX_FRAMES && tdata[n_frames*COLS] != 8'h00) n_frames++;

    repeat (8) @(negedge clk);
    rst = 1'b0;

    // idle after reset, nothing parsed yet
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      assert (!done && scalefac_l == '0 && scalefac_s == '0) else begin
        $display("ERR %0t: outputs not idle after reset", $time);
        errors++;
      end
    end

    if (n_frames == 0) begin
      $display("no frames could be read from the test data file");
      errors++;
    end
    for (int f = 0; f < n_frames; f++) run_frame(f);

    $display("%0d of %0d tests ok, %0d check errors", tests_ok, n_frames, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // worst frame plus slack, per frame in the file
  initial begin
    longint limit;
    #1;
    limit = (longint'(n_frames) * (36 * 4 * 2 + 20) + 40) * 100;
    #(limit);
    $display("timeout: the frames did not finish within %0d ns", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

// File: verification/sf_parser_testdata.txt
// id mode compress, then fields 0..35 (hex, masked to the slen width)
// mode: bit0 short block, bit1 abort first, bit2 stray bits after done, bit3 wsf with type 1
01 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
02 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
03 0 2 0 0 0 0 0 0 0 0 0 0 0 3 2 1 3 0 1 2 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
04 0 3 0 0 0 0 0 0 0 0 0 0 0 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
05 0 4 7 5 2 6 1 0 3 4 6 7 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
06 0 5 1 0 1 1 0 1 0 0 1 1 1 0 1 1 0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
07 0 6 1 0 1 1 0 1 0 0 1 1 1 3 2 1 3 0 1 2 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
08 0 7 1 0 1 1 0 1 0 0 1 1 1 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
09 0 8 3 1 2 0 2 3 1 1 0 3 2 0 1 1 0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0a 0 9 3 1 2 0 2 3 1 1 0 3 2 3 2 1 3 0 1 2 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0b 0 a 3 1 2 0 2 3 1 1 0 3 2 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0c 0 b 7 5 2 6 1 0 3 4 6 7 2 0 1 1 0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0d 0 c 7 5 2 6 1 0 3 4 6 7 2 3 2 1 3 0 1 2 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0e 0 d 7 5 2 6 1 0 3 4 6 7 2 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0f 0 e f a 5 c 3 9 0 e 7 1 b 3 2 1 3 0 1 2 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
10 0 f f a 5 c 3 9 0 e 7 1 b 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
11 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
12 1 4 7 5 2 6 1 0 3 4 6 7 2 5 1 3 0 6 4 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
13 1 5 1 0 1 1 0 1 0 0 1 1 1 0 0 1 0 1 1 0 0 1 1 0 1 0 0 1 1 1 0 0 1 0 1 1 0 1
14 1 9 3 1 2 0 2 3 1 1 0 3 2 2 1 0 3 1 2 3 3 2 1 3 0 1 2 2 3 0 1 1 3 2 0 2 1 3
15 1 d 7 5 2 6 1 0 3 4 6 7 2 5 1 3 0 6 4 7 7 4 6 0 3 1 5 2 7 6 4 3 0 1 6 2 5 7
16 1 f f a 5 c 3 9 0 e 7 1 b 6 d 2 8 4 a f 7 4 6 0 3 1 5 2 7 6 4 3 0 1 6 2 5 7
17 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 2 1 3 0 1 2 2 3 0 1 1 3 2 0 2 1 3
18 4 f f a 5 c 3 9 0 e 7 1 b 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
19 5 e f a 5 c 3 9 0 e 7 1 b 6 d 2 8 4 a f 3 2 1 3 0 1 2 2 3 0 1 1 3 2 0 2 1 3
1a 2 a 3 1 2 0 2 3 1 1 0 3 2 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1b 3 b 7 5 2 6 1 0 3 4 6 7 2 5 1 3 0 6 4 7 0 1 1 0 1 0 0 1 1 1 0 0 1 0 1 1 0 1
1c 6 f f a 5 c 3 9 0 e 7 1 b 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1d 8 7 1 0 1 1 0 1 0 0 1 1 1 7 4 6 0 3 1 5 2 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1e 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 7 4 6 0 3 1 5 2 7 6 4 3 0 1 6 2 5 7
1f 5 4 7 5 2 6 1 0 3 4 6 7 2 5 1 3 0 6 4 7 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
20 2 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// File: verilog.f
+incdir+src
src/sf_pkg.sv
src/sf_slen_decode.sv
src/sf_field_walker.sv
src/sf_store.sv
src/sf_parser.sv
verification/sf_parser_chk.sv
verification/sf_parser_tb.sv
